// ==== mem_1r1w.f ====
+incdir+verilog
verilog/mem_1r1w_pkg.sv
verilog/sp_bank.sv
verilog/bank_map_table.sv
verilog/conflict_steer.sv
verilog/read_return.sv
verilog/mem_1r1w_top.sv
test/mem_1r1w_tb.sv

// ==== Bender.yml ====
package:
  name: mem_1r1w

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mem_1r1w_pkg.sv
      - verilog/sp_bank.sv
      - verilog/bank_map_table.sv
      - verilog/conflict_steer.sv
      - verilog/read_return.sv
      - verilog/mem_1r1w_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - test/mem_1r1w_tb.sv

// ==== test/mem_1r1w_tb.sv ====
`timescale 1ns/1ps

`include "mem_1r1w_consts.svh"

// Testbench for the one-read one-write memory.
// Requests come from a table built at time zero and are checked against a
// reference array, with the read always seeing memory before the write.
module mem_1r1w_tb
  import mem_1r1w_pkg::*;
();

  localparam int NUM_RAND = 100;
  localparam int NUM_ADDR = 1 << (`MEM_BITVBNK + `MEM_BITROW);

  typedef struct packed {
    logic  rd;
    addr_t ra;
    logic  wr;
    addr_t wa;
    data_t d;
  } stim_t;

  typedef struct packed {
    logic  vld;
    logic  known;
    data_t data;
  } expect_t;

  logic  clk;
  logic  rst_n;
  logic  ready;
  logic  read;
  addr_t rd_adr;
  logic  write;
  addr_t wr_adr;
  data_t din;
  data_t rd_dout;
  logic  rd_vld;

  stim_t   table_q [$];
  expect_t exp_q [$];
  data_t   ref_mem [NUM_ADDR];
  logic    ref_valid [NUM_ADDR];
  int      errors = 0;
  int      checks = 0;
  int      cycles = 0;
  int      limit = 0;
  int      sweep_cycles;

  mem_1r1w_top dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .ready   (ready),
    .read    (read),
    .rd_adr  (rd_adr),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .rd_dout (rd_dout),
    .rd_vld  (rd_vld)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Cycle limit counted from reset release.
  initial begin
    @(posedge rst_n);
    while (cycles <= limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles after reset", limit);
    $display("Checks run: %0d, errors: %0d", checks, errors + 1);
    $display("Checks failed");
    $finish;
  end

  task automatic check_value(input string name, input data_t expected, input data_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
    end
  endtask

  task automatic add_entry(input logic r, input addr_t ra, input logic w, input addr_t wa,
                           input data_t d);
    stim_t s;
    s.rd = r;
    s.ra = ra;
    s.wr = w;
    s.wa = wa;
    s.d  = d;
    table_q.push_back(s);
  endtask

  task automatic build_table();
    addr_t a;
    logic  r;
    logic  w;
    addr_t ra;
    addr_t wa;
    data_t d;
    // Write then read back, spread over every virtual bank.
    for (int i = 0; i < 8; i++) begin
      a = addr_t'(i * 9);
      add_entry(1'b0, '0, 1'b1, a, 32'h1000_0000 + i);
      add_entry(1'b1, a, 1'b0, '0, '0);
    end
    // Fill rows 0 to 5 of virtual bank 1.
    for (int i = 0; i < 6; i++) begin
      add_entry(1'b0, '0, 1'b1, addr_t'(16 + i), 32'h2000_0000 + i);
    end
    // Read rows 0 to 5 while writing rows 8 to 13 of the same virtual bank.
    for (int i = 0; i < 6; i++) begin
      add_entry(1'b1, addr_t'(16 + i), 1'b1, addr_t'(24 + i), 32'h3000_0000 + i);
    end
    for (int i = 0; i < 6; i++) begin
      add_entry(1'b1, addr_t'(24 + i), 1'b0, '0, '0);
    end
    for (int i = 0; i < 6; i++) begin
      add_entry(1'b1, addr_t'(16 + i), 1'b0, '0, '0);
    end
    // Same address read and written in one cycle, then read again.
    add_entry(1'b1, addr_t'(36), 1'b1, addr_t'(36), 32'h4000_0024);
    add_entry(1'b1, addr_t'(36), 1'b0, '0, '0);
    add_entry(1'b1, addr_t'(63), 1'b1, addr_t'(63), 32'h4000_003f);
    add_entry(1'b1, addr_t'(63), 1'b0, '0, '0);
    for (int i = 0; i < NUM_RAND; i++) begin
      r  = ($urandom_range(0, 3) != 0);
      ra = addr_t'($urandom);
      w  = ($urandom_range(0, 3) != 0);
      wa = addr_t'($urandom);
      d  = data_t'($urandom);
      add_entry(r, ra, w, wa, d);
    end
  endtask

  // The model is read before it is written, as the memory does.
  task automatic drive_entry(input stim_t s);
    expect_t e;
    e.vld   = s.rd;
    e.known = s.rd && ref_valid[s.ra];
    e.data  = ref_mem[s.ra];
    exp_q.push_back(e);
    read   = s.rd;
    rd_adr = s.ra;
    write  = s.wr;
    wr_adr = s.wa;
    din    = s.d;
    if (s.wr) begin
      ref_mem[s.wa]   = s.d;
      ref_valid[s.wa] = 1'b1;
    end
  endtask

  task automatic compare_output(input expect_t e);
    check_value("rd_vld", data_t'(e.vld), data_t'(rd_vld));
    if (e.vld && e.known) begin
      check_value("rd_dout", e.data, rd_dout);
    end
  endtask

  initial begin
    rst_n  = 1'b0;
    read   = 1'b0;
    write  = 1'b0;
    rd_adr = '0;
    wr_adr = '0;
    din    = '0;
    void'($urandom(3));
    build_table();
    limit = `MEM_NUMROW + table_q.size() + 50;
    for (int a = 0; a < NUM_ADDR; a++) begin
      ref_valid[a] = 1'b0;
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    // Requests made during the map sweep must be ignored.
    read   = 1'b1;
    rd_adr = addr_t'(5);
    write  = 1'b1;
    wr_adr = addr_t'(5);
    din    = 32'hdead_beef;
    sweep_cycles = 0;
    while (!ready) begin
      check_value("rd_vld", '0, data_t'(rd_vld));
      @(negedge clk);
      sweep_cycles++;
    end
    if (sweep_cycles != `MEM_NUMROW) begin
      errors++;
      $display("ready rose %0d cycles after reset instead of %0d", sweep_cycles, `MEM_NUMROW);
    end

    // Two idle slots cover the read latency before the first table entry.
    exp_q.push_back('0);
    exp_q.push_back('0);
    for (int i = 0; i < table_q.size() + `MEM_RD_LAT; i++) begin
      if (i > 0) begin
        @(negedge clk);
      end
      check_value("ready", data_t'(1'b1), data_t'(ready));
      compare_output(exp_q.pop_front());
      if (i < table_q.size()) begin
        drive_entry(table_q[i]);
      end else begin
        drive_entry(stim_t'('0));
      end
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== verilog/mem_1r1w_top.sv ====
`timescale 1ns/1ps

`include "mem_1r1w_consts.svh"

// One-read one-write memory built from single-port banks plus one spare bank.
// A read and a write can both be accepted every cycle once ready is high.
module mem_1r1w_top
  import mem_1r1w_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  output logic  ready,

  input  logic  read,
  input  addr_t rd_adr,
  input  logic  write,
  input  addr_t wr_adr,
  input  data_t din,

  output data_t rd_dout,
  output logic  rd_vld
);

  row_t                    rd_row;
  row_t                    wr_row;
  map_row_t                rd_map;
  map_row_t                wr_map;

  logic                    swap_en;
  row_t                    swap_row;
  vbank_t                  swap_vbank;
  pbank_t                  swap_pbank;

  logic [`MEM_NUMPBNK-1:0] bank_en;
  logic [`MEM_NUMPBNK-1:0] bank_we;
  row_t                    bank_row  [`MEM_NUMPBNK];
  data_t                   bank_din;
  data_t                   bank_dout [`MEM_NUMPBNK];

  pbank_t                  rd_pbank;
  logic                    rd_issue;

  bank_map_table map_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .ready      (ready),
    .rd_row     (rd_row),
    .rd_map     (rd_map),
    .wr_row     (wr_row),
    .wr_map     (wr_map),
    .swap_en    (swap_en),
    .swap_row   (swap_row),
    .swap_vbank (swap_vbank),
    .swap_pbank (swap_pbank)
  );

  conflict_steer steer_i (
    .read       (read),
    .rd_adr     (rd_adr),
    .write      (write),
    .wr_adr     (wr_adr),
    .din        (din),
    .ready      (ready),
    .rd_row     (rd_row),
    .rd_map     (rd_map),
    .wr_row     (wr_row),
    .wr_map     (wr_map),
    .swap_en    (swap_en),
    .swap_row   (swap_row),
    .swap_vbank (swap_vbank),
    .swap_pbank (swap_pbank),
    .bank_en    (bank_en),
    .bank_we    (bank_we),
    .bank_row   (bank_row),
    .bank_din   (bank_din),
    .rd_pbank   (rd_pbank),
    .rd_issue   (rd_issue)
  );

  // Physical banks, including the spare.
  for (genvar p = 0; p < `MEM_NUMPBNK; p++) begin : g_bank
    sp_bank bank_i (
      .clk  (clk),
      .en   (bank_en[p]),
      .we   (bank_we[p]),
      .row  (bank_row[p]),
      .din  (bank_din),
      .dout (bank_dout[p])
    );
  end

  read_return ret_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_issue  (rd_issue),
    .rd_pbank  (rd_pbank),
    .bank_dout (bank_dout),
    .rd_dout   (rd_dout),
    .rd_vld    (rd_vld)
  );

endmodule

// ==== verilog/read_return.sv ====
`timescale 1ns/1ps

`include "mem_1r1w_consts.svh"

// Read return path.
// The issued bank number travels one stage alongside the bank read, then
// picks that bank's output into the registered read data.
module read_return
  import mem_1r1w_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   rd_issue,
  input  pbank_t rd_pbank,
  input  data_t  bank_dout [`MEM_NUMPBNK],
  output data_t  rd_dout,
  output logic   rd_vld
);

  logic   issue_q;
  pbank_t pbank_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_q <= 1'b0;
      rd_vld  <= 1'b0;
    end else begin
      issue_q <= rd_issue;
      rd_vld  <= issue_q;
    end
  end

  // Data follows the valid pipeline and holds its value between reads.
  always_ff @(posedge clk) begin
    pbank_q <= rd_pbank;
    if (issue_q) begin
      rd_dout <= bank_dout[pbank_q];
    end
  end

endmodule

// ==== verilog/conflict_steer.sv ====
`timescale 1ns/1ps

`include "mem_1r1w_consts.svh"

// Maps the read and the write onto physical banks.
// The read always keeps its bank.  A write that lands on the same physical
// bank is moved to the spare bank of its own row, and the map is updated so
// the spare becomes the new home of the written virtual bank.
module conflict_steer
  import mem_1r1w_pkg::*;
(
  input  logic                    read,
  input  addr_t                   rd_adr,
  input  logic                    write,
  input  addr_t                   wr_adr,
  input  data_t                   din,
  input  logic                    ready,

  output row_t                    rd_row,
  input  map_row_t                rd_map,
  output row_t                    wr_row,
  input  map_row_t                wr_map,

  output logic                    swap_en,
  output row_t                    swap_row,
  output vbank_t                  swap_vbank,
  output pbank_t                  swap_pbank,

  output logic [`MEM_NUMPBNK-1:0] bank_en,
  output logic [`MEM_NUMPBNK-1:0] bank_we,
  output row_t                    bank_row [`MEM_NUMPBNK],
  output data_t                   bank_din,

  output pbank_t                  rd_pbank,
  output logic                    rd_issue
);

  logic                    rd_acc;
  logic                    wr_acc;
  vbank_t                  rd_vbank;
  vbank_t                  wr_vbank;
  pbank_t                  wr_home;
  pbank_t                  wr_pbank;
  pbank_t                  spare;
  logic [`MEM_NUMPBNK-1:0] used;
  logic                    conflict;

  assign rd_acc = read && ready;
  assign wr_acc = write && ready;

  // Address split into virtual bank and row.
  assign rd_vbank = rd_adr[`MEM_BITVBNK+`MEM_BITROW-1:`MEM_BITROW];
  assign rd_row   = rd_adr[`MEM_BITROW-1:0];
  assign wr_vbank = wr_adr[`MEM_BITVBNK+`MEM_BITROW-1:`MEM_BITROW];
  assign wr_row   = wr_adr[`MEM_BITROW-1:0];

  assign rd_pbank = rd_map[rd_vbank];
  assign wr_home  = wr_map[wr_vbank];

  // The spare is the one physical bank that no entry of the write row names.
  always_comb begin
    used  = '0;
    spare = '0;
    for (int v = 0; v < `MEM_NUMVBNK; v++) begin
      used[wr_map[v]] = 1'b1;
    end
    for (int p = `MEM_NUMPBNK - 1; p >= 0; p--) begin
      if (!used[p]) begin
        spare = pbank_t'(p);
      end
    end
  end

  // Rows may differ; a clash on the physical bank is enough to conflict.
  assign conflict = rd_acc && wr_acc && (rd_pbank == wr_home);
  assign wr_pbank = conflict ? spare : wr_home;

  // The old home drops out of the row and so becomes the new spare.
  assign swap_en    = conflict;
  assign swap_row   = wr_row;
  assign swap_vbank = wr_vbank;
  assign swap_pbank = spare;

  // One request per physical bank.  After steering the read and the write
  // never share a bank.
  always_comb begin
    for (int p = 0; p < `MEM_NUMPBNK; p++) begin
      bank_we[p]  = wr_acc && (wr_pbank == pbank_t'(p));
      bank_en[p]  = bank_we[p] || (rd_acc && (rd_pbank == pbank_t'(p)));
      bank_row[p] = bank_we[p] ? wr_row : rd_row;
    end
  end

  assign bank_din = din;
  assign rd_issue = rd_acc;

endmodule

// ==== verilog/bank_map_table.sv ====
`timescale 1ns/1ps

`include "mem_1r1w_consts.svh"

// Per-row bank map.
// Each row records which physical bank holds each virtual bank in that row.
// After reset the table is swept to the identity mapping one row per cycle,
// and ready stays low until the sweep is over.
module bank_map_table
  import mem_1r1w_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  output logic     ready,

  input  row_t     rd_row,
  output map_row_t rd_map,

  input  row_t     wr_row,
  output map_row_t wr_map,

  input  logic     swap_en,
  input  row_t     swap_row,
  input  vbank_t   swap_vbank,
  input  pbank_t   swap_pbank
);

  map_row_t    map_q [`MEM_NUMROW];
  init_state_t state;
  row_t        init_row;
  map_row_t    ident_row;

  // Virtual bank v starts out in physical bank v, leaving the last physical
  // bank as the spare of every row.
  always_comb begin
    for (int v = 0; v < `MEM_NUMVBNK; v++) begin
      ident_row[v] = pbank_t'(v);
    end
  end

  // Sweep FSM.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= INIT_SWEEP;
      init_row <= '0;
    end else if (state == INIT_SWEEP) begin
      init_row <= row_t'(init_row + 1'b1);
      if (init_row == row_t'(`MEM_NUMROW - 1)) begin
        state <= INIT_DONE;
      end
    end
  end

  assign ready = (state == INIT_DONE);

  // Map storage.
  // Swaps only arrive while ready is high, so they never collide with the sweep.
  always_ff @(posedge clk) begin
    if (state == INIT_SWEEP) begin
      map_q[init_row] <= ident_row;
    end else if (swap_en) begin
      map_q[swap_row][swap_vbank] <= swap_pbank;
    end
  end

  // Both lookups are combinational so steering can resolve banks in the
  // same cycle as the request.
  assign rd_map = map_q[rd_row];
  assign wr_map = map_q[wr_row];

endmodule

// ==== verilog/sp_bank.sv ====
`timescale 1ns/1ps

`include "mem_1r1w_consts.svh"

// Behavioral model of one single-port SRAM bank.
// A cycle either writes or reads, never both, and read data appears one
// cycle after the request.
module sp_bank
  import mem_1r1w_pkg::*;
(
  input  logic  clk,
  input  logic  en,
  input  logic  we,
  input  row_t  row,
  input  data_t din,
  output data_t dout
);

  data_t mem [`MEM_NUMROW];

  // The array has no reset, so contents are unknown until written.
  always_ff @(posedge clk) begin
    if (en && we) begin
      mem[row] <= din;
    end
  end

  // Read data is held when the bank is idle or writing.
  always_ff @(posedge clk) begin
    if (en && !we) begin
      dout <= mem[row];
    end
  end

endmodule

// ==== verilog/mem_1r1w_pkg.sv ====
package mem_1r1w_pkg;

  `include "mem_1r1w_consts.svh"

  // One data word as stored in a bank.
  typedef logic [`MEM_WIDTH-1:0] data_t;

  // Bank and row indices.
  typedef logic [`MEM_BITVBNK-1:0] vbank_t;
  typedef logic [`MEM_BITPBNK-1:0] pbank_t;
  typedef logic [`MEM_BITROW-1:0]  row_t;

  // A logical address is the virtual bank in the upper field followed by the row.
  typedef logic [`MEM_BITVBNK+`MEM_BITROW-1:0] addr_t;

  // One row of the bank map.
  // Entry v holds the physical bank that currently stores virtual bank v in that row.
  typedef pbank_t [`MEM_NUMVBNK-1:0] map_row_t;

  // States of the map initialization after reset.
  typedef enum logic {
    INIT_SWEEP = 1'b0,
    INIT_DONE  = 1'b1
  } init_state_t;

endpackage

// ==== verilog/mem_1r1w_consts.svh ====
`ifndef MEM_1R1W_CONSTS_SVH
`define MEM_1R1W_CONSTS_SVH

// Width of one data word.
`define MEM_WIDTH 32

// Virtual banks seen through the address, and the physical banks behind them.
// There is one physical bank more than virtual banks, which gives every row
// exactly one spare.
`define MEM_NUMVBNK 4
`define MEM_NUMPBNK 5

// Rows in each bank.
`define MEM_NUMROW 16

// Index widths for the counts above.
`define MEM_BITVBNK 2
`define MEM_BITPBNK 3
`define MEM_BITROW 4

// Cycles from read acceptance to rd_vld.
`define MEM_RD_LAT 2

`endif
